// File: include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath widths
`define DATA_W      40 // Operand and register width
`define REG_ADDR_W  5  // Register number width
`define PC_W        30 // Word aligned PC, byte offset bits dropped
`define INSTR_W     32 // One instruction slot

// Register numbers with a fixed meaning
`define LINK_REG    30 // Written by BL
`define UNUSED_REG  31 // No register, also stands for the PC

`endif

// File: hdl/isa_pkg.sv
package isa_pkg;

	// Major opcode in instr[31:27]
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		AND  = 5'd1,
		BIC  = 5'd2,
		OR   = 5'd3,
		RSB  = 5'd4, // Reverse subtract
		SUB  = 5'd5,
		CMP  = 5'd6, // Flags only
		LDR  = 5'd7,
		STR  = 5'd8,
		B    = 5'd9,
		BL   = 5'd10, // Branch and link to r30
		NOOP = 5'd11,
		HALT = 5'd12
	} opcode_e;

	// Instruction word as seen by decode
	// Fields below bit 22 move around per opcode class
	//   ALU  rd[21:17] rm[16:12] rn[11:7]  or imm[11:0]
	//   CMP  rm[21:17] rn[16:12] or imm[16:0]
	//   MEM  rd[22:18] base[17:13] imm[12:0]
	//   BR   rn[21:17] or imm[21:0]
	typedef struct packed {
		opcode_e     opcode; // [31:27]
		logic [3:0]  spare;  // [26:23] Reserved
		logic        imm;    // [22] Immediate form select
		logic [21:0] body;   // [21:0] Operand fields
	} instr_t;

endpackage

// File: hdl/pipe_pkg.sv
`include "decode_settings.svh"

package pipe_pkg;

	typedef logic [`DATA_W-1:0]     data_t;     // Register and operand data
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // Register number
	typedef logic [`PC_W-1:0]       pc_t;       // Word address

	// Issue state of the decode stage
	typedef enum logic {
		RUNNING = 1'b0, // Normal issue
		HALTED  = 1'b1  // Halt retired, issue stopped until reset
	} issue_state_e;

endpackage

// File: hdl/decode_intf.sv
// Read port pair of the register file, one per slot
interface rf_read_if;
	pipe_pkg::reg_addr_t addr_rm; // First operand register
	pipe_pkg::reg_addr_t addr_rn; // Second operand register
	pipe_pkg::data_t     data_rm; // Bypassed read data
	pipe_pkg::data_t     data_rn;

	modport decoder (
		output addr_rm,
		output addr_rn,
		input  data_rm,
		input  data_rn
	);

	modport regs (
		input  addr_rm,
		input  addr_rn,
		output data_rm,
		output data_rn
	);
endinterface

// Decoded slot handed to issue control, valid within the cycle
interface slot_if;
	isa_pkg::opcode_e    opcode;
	pipe_pkg::data_t     rm;      // Operand A
	pipe_pkg::data_t     rn;      // Operand B, register or immediate
	pipe_pkg::data_t     ro;      // Store data or link PC
	pipe_pkg::reg_addr_t rd;      // Destination, 31 when none
	logic                has_wb;  // Slot writes a register
	pipe_pkg::reg_addr_t addr_rm; // Registers actually read
	pipe_pkg::reg_addr_t addr_rn;

	modport decoder (
		output opcode, rm, rn, ro, rd, has_wb, addr_rm, addr_rn
	);

	modport control (
		input opcode, rm, rn, ro, rd, has_wb, addr_rm, addr_rn
	);
endinterface

// File: hdl/reg_file.sv
`include "decode_settings.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst,
	rf_read_if.regs             rd0,      // Slot 0 reads
	rf_read_if.regs             rd1,      // Slot 1 reads
	input  pipe_pkg::reg_addr_t wr_addr0,
	input  pipe_pkg::reg_addr_t wr_addr1,
	input  pipe_pkg::data_t     wr_data0,
	input  pipe_pkg::data_t     wr_data1,
	input  logic                wr_en0,
	input  logic                wr_en1,
	input  logic                halted    // Blocks all write-back
);
	localparam pipe_pkg::reg_addr_t NONE = pipe_pkg::reg_addr_t'(`UNUSED_REG);

	pipe_pkg::data_t regs [0:`UNUSED_REG-1]; // r0..r30, r31 has no storage
	logic            we0;
	logic            we1;

	// Effective write enables
	assign we0 = wr_en0 && (wr_addr0 != NONE) && !halted; // r31 is the PC
	assign we1 = wr_en1 && (wr_addr1 != NONE) && !halted;

	// One read port with same-cycle bypass
	function automatic pipe_pkg::data_t read_port(input pipe_pkg::reg_addr_t addr);
		pipe_pkg::data_t value;
		if (we1 && addr == wr_addr1)
			value = wr_data1; // Port 1 is younger, wins
		else if (we0 && addr == wr_addr0)
			value = wr_data0;
		else if (addr == NONE)
			value = '0; // Unused read
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb begin
		rd0.data_rm = read_port(rd0.addr_rm);
		rd0.data_rn = read_port(rd0.addr_rn);
		rd1.data_rm = read_port(rd1.addr_rm);
		rd1.data_rn = read_port(rd1.addr_rn);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `UNUSED_REG; i++)
				regs[i] <= '0;
		end else begin
			if (we0)
				regs[wr_addr0] <= wr_data0;
			if (we1)
				regs[wr_addr1] <= wr_data1; // Same address on both ports keeps port 1
		end
	end

endmodule

// File: hdl/slot_decoder.sv
`include "decode_settings.svh"

module slot_decoder #(
	parameter int unsigned SLOT_OFFSET = 0 // Word offset of this slot in the fetch pair
) (
	input  isa_pkg::instr_t instr,
	input  pipe_pkg::pc_t   pc,    // PC of slot 0
	rf_read_if.decoder      rf,
	slot_if.decoder         slot
);
	localparam pipe_pkg::reg_addr_t NONE = pipe_pkg::reg_addr_t'(`UNUSED_REG);
	localparam pipe_pkg::reg_addr_t LINK = pipe_pkg::reg_addr_t'(`LINK_REG);

	logic [`INSTR_W-1:0] raw;     // Flat view for field slicing
	pipe_pkg::pc_t       own_pc;  // PC of this slot
	pipe_pkg::data_t     imm_alu; // Sign extended immediates per format
	pipe_pkg::data_t     imm_cmp;
	pipe_pkg::data_t     imm_mem;
	pipe_pkg::data_t     imm_br;
	pipe_pkg::reg_addr_t addr_rm;
	pipe_pkg::reg_addr_t addr_rn;

	assign raw    = instr;
	assign own_pc = pc + pipe_pkg::pc_t'(SLOT_OFFSET);

	assign imm_alu = {{(`DATA_W-12){raw[11]}}, raw[11:0]};
	assign imm_cmp = {{(`DATA_W-17){raw[16]}}, raw[16:0]};
	assign imm_mem = {{(`DATA_W-13){raw[12]}}, raw[12:0]}; // Address offset
	assign imm_br  = {{(`DATA_W-22){raw[21]}}, raw[21:0]}; // Branch offset

	always_comb begin
		addr_rm     = NONE; // Nothing read unless the opcode needs it
		addr_rn     = NONE;
		slot.rd     = NONE;
		slot.rm     = '0;
		slot.rn     = '0;
		slot.ro     = '0;
		slot.has_wb = 1'b0;
		case (instr.opcode)
			isa_pkg::ADD, isa_pkg::AND, isa_pkg::BIC,
			isa_pkg::OR, isa_pkg::RSB, isa_pkg::SUB: begin
				addr_rm     = raw[16:12];
				slot.rm     = rf.data_rm;
				slot.rd     = raw[21:17];
				slot.has_wb = 1'b1;
				if (instr.imm) begin
					slot.rn = imm_alu; // No rn read in immediate form
				end else begin
					addr_rn = raw[11:7];
					slot.rn = rf.data_rn;
				end
			end
			isa_pkg::CMP: begin
				addr_rm = raw[21:17];
				slot.rm = rf.data_rm;
				if (instr.imm) begin
					slot.rn = imm_cmp;
				end else begin
					addr_rn = raw[16:12];
					slot.rn = rf.data_rn;
				end
			end
			isa_pkg::LDR: begin
				addr_rm     = raw[17:13]; // Base
				slot.rm     = rf.data_rm;
				slot.rn     = imm_mem;
				slot.rd     = raw[22:18];
				slot.has_wb = 1'b1;
			end
			isa_pkg::STR: begin
				addr_rm = raw[17:13]; // Base
				addr_rn = raw[22:18]; // Store data comes through the rn port
				slot.rm = rf.data_rm;
				slot.rn = imm_mem;
				slot.ro = rf.data_rn; // rn carries the offset so data rides on ro
			end
			isa_pkg::B, isa_pkg::BL: begin
				slot.rm = pipe_pkg::data_t'(own_pc); // Branch base is this slot's PC
				if (instr.imm) begin
					slot.rn = imm_br;
				end else begin
					addr_rn = raw[21:17];
					slot.rn = rf.data_rn;
				end
				if (instr.opcode == isa_pkg::BL) begin
					slot.rd     = LINK; // Return address into r30
					slot.ro     = pipe_pkg::data_t'(own_pc);
					slot.has_wb = 1'b1;
				end
			end
			default: ; // NOOP, HALT and unknown codes read nothing
		endcase
	end

	assign rf.addr_rm   = addr_rm;
	assign rf.addr_rn   = addr_rn;
	assign slot.addr_rm = addr_rm; // Used by the pairing hazard check
	assign slot.addr_rn = addr_rn;
	assign slot.opcode  = instr.opcode;

endmodule

// File: hdl/issue_control.sv
`include "decode_settings.svh"

module issue_control (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall_decode, // Back-pressure from later stages
	input  logic                halt_in_wb,   // HALT reached write-back
	input  logic                branch_en,    // Redirect in progress
	slot_if.control             slot0,
	slot_if.control             slot1,
	output pipe_pkg::data_t     rm0_ex,
	output pipe_pkg::data_t     rn0_ex,
	output pipe_pkg::data_t     ro0_ex,
	output pipe_pkg::data_t     rm1_ex,
	output pipe_pkg::data_t     rn1_ex,
	output pipe_pkg::data_t     ro1_ex,
	output pipe_pkg::reg_addr_t rd0_ex,
	output pipe_pkg::reg_addr_t rd1_ex,
	output isa_pkg::opcode_e    opcode0_ex,
	output isa_pkg::opcode_e    opcode1_ex,
	output logic                issue0,       // Slot 0 goes to execute this cycle
	output logic                issue1,
	output logic                halted,
	output logic                stall0,       // Stall flags seen by fetch
	output logic                stall1
);
	localparam pipe_pkg::reg_addr_t NONE = pipe_pkg::reg_addr_t'(`UNUSED_REG);

	pipe_pkg::issue_state_e state;
	logic                   stall_slot0;
	logic                   stall_slot1;
	logic                   hazard;      // Slot 1 depends on slot 0

	// Slot 1 reads what slot 0 is about to write
	assign hazard = slot0.has_wb && (slot0.rd != NONE)
		&& ((slot0.rd == slot1.addr_rm) || (slot0.rd == slot1.addr_rn))
		&& (slot1.opcode != isa_pkg::NOOP);

	assign stall_slot0 = stall_decode;
	assign stall_slot1 = stall_slot0 || (slot0.opcode == isa_pkg::HALT) || hazard;

	assign halted = (state == pipe_pkg::HALTED);
	assign issue0 = !stall_slot0 && !halted;
	assign issue1 = !stall_slot1 && !halted; // Implies issue0

	assign stall0 = stall_slot0 && !branch_en; // Fetch ignores stall on redirect
	assign stall1 = stall_slot1 && !branch_en;

	// Halt is sticky until reset
	always_ff @(posedge clk) begin
		if (rst)
			state <= pipe_pkg::RUNNING;
		else if (halt_in_wb)
			state <= pipe_pkg::HALTED;
	end

	// Execute control, a slot that does not issue becomes a NOOP with no rd
	always_ff @(posedge clk) begin
		if (rst) begin
			opcode0_ex <= isa_pkg::NOOP;
			opcode1_ex <= isa_pkg::NOOP;
			rd0_ex     <= NONE;
			rd1_ex     <= NONE;
		end else begin
			opcode0_ex <= issue0 ? slot0.opcode : isa_pkg::NOOP;
			opcode1_ex <= issue1 ? slot1.opcode : isa_pkg::NOOP;
			rd0_ex     <= issue0 ? slot0.rd : NONE;
			rd1_ex     <= issue1 ? slot1.rd : NONE;
		end
	end

	// Operand payload, qualified by the opcode downstream
	always_ff @(posedge clk) begin
		rm0_ex <= slot0.rm;
		rn0_ex <= slot0.rn;
		ro0_ex <= slot0.ro;
		rm1_ex <= slot1.rm;
		rn1_ex <= slot1.rn;
		ro1_ex <= slot1.ro;
	end

endmodule

// File: hdl/pc_sequencer.sv
module pc_sequencer (
	input  logic          clk,
	input  logic          rst,
	input  logic          issue0,      // Slot 0 issued
	input  logic          issue1,      // Slot 1 issued as well
	input  logic          branch_en,
	input  pipe_pkg::pc_t branch_addr, // Redirect target from execute
	output pipe_pkg::pc_t pc,          // PC of the pair in decode
	output pipe_pkg::pc_t next_pc      // Next fetch address
);

	// Redirect first, then advance by the number of slots issued
	always_comb begin
		if (branch_en)
			next_pc = branch_addr;
		else if (issue1)
			next_pc = pc + pipe_pkg::pc_t'(2); // Whole pair consumed
		else if (issue0)
			next_pc = pc + pipe_pkg::pc_t'(1); // Slot 1 refetched as new slot 0
		else
			next_pc = pc; // Hold on stall
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else
			pc <= next_pc;
	end

endmodule

// File: hdl/dual_decode_top.sv
module dual_decode_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall_decode,
	input  logic                halt_in_wb,
	input  logic                branch_en,
	input  isa_pkg::instr_t     instr0,      // Older instruction of the pair
	input  isa_pkg::instr_t     instr1,
	input  pipe_pkg::reg_addr_t wb_addr0,
	input  pipe_pkg::reg_addr_t wb_addr1,
	input  pipe_pkg::data_t     wb_data0,
	input  pipe_pkg::data_t     wb_data1,
	input  logic                wb_en0,
	input  logic                wb_en1,
	input  pipe_pkg::pc_t       branch_addr,
	output pipe_pkg::data_t     rm0_ex,
	output pipe_pkg::data_t     rn0_ex,
	output pipe_pkg::data_t     ro0_ex,
	output pipe_pkg::data_t     rm1_ex,
	output pipe_pkg::data_t     rn1_ex,
	output pipe_pkg::data_t     ro1_ex,
	output pipe_pkg::reg_addr_t rd0_ex,
	output pipe_pkg::reg_addr_t rd1_ex,
	output isa_pkg::opcode_e    opcode0_ex,
	output isa_pkg::opcode_e    opcode1_ex,
	output pipe_pkg::pc_t       next_pc,
	output logic                stall0,
	output logic                stall1
);
	pipe_pkg::pc_t pc;     // Current pair address
	logic          issue0;
	logic          issue1;
	logic          halted;

	rf_read_if rf0 ();    // Slot 0 register reads
	rf_read_if rf1 ();
	slot_if    s0 ();     // Decoded slots
	slot_if    s1 ();

	reg_file i_reg_file (
		.clk(clk), .rst(rst), .rd0(rf0), .rd1(rf1),
		.wr_addr0(wb_addr0), .wr_addr1(wb_addr1),
		.wr_data0(wb_data0), .wr_data1(wb_data1),
		.wr_en0(wb_en0), .wr_en1(wb_en1), .halted(halted)
	);

	slot_decoder #(.SLOT_OFFSET(0)) i_dec0 (.instr(instr0), .pc(pc), .rf(rf0), .slot(s0));
	slot_decoder #(.SLOT_OFFSET(1)) i_dec1 (.instr(instr1), .pc(pc), .rf(rf1), .slot(s1));

	issue_control i_issue (
		.clk(clk), .rst(rst), .stall_decode(stall_decode),
		.halt_in_wb(halt_in_wb), .branch_en(branch_en),
		.slot0(s0), .slot1(s1),
		.rm0_ex(rm0_ex), .rn0_ex(rn0_ex), .ro0_ex(ro0_ex),
		.rm1_ex(rm1_ex), .rn1_ex(rn1_ex), .ro1_ex(ro1_ex),
		.rd0_ex(rd0_ex), .rd1_ex(rd1_ex),
		.opcode0_ex(opcode0_ex), .opcode1_ex(opcode1_ex),
		.issue0(issue0), .issue1(issue1), .halted(halted),
		.stall0(stall0), .stall1(stall1)
	);

	pc_sequencer i_pc (
		.clk(clk), .rst(rst), .issue0(issue0), .issue1(issue1),
		.branch_en(branch_en), .branch_addr(branch_addr),
		.pc(pc), .next_pc(next_pc)
	);

endmodule

// File: sim/tb_decode_chk.sv
module tb_decode_chk (
	input logic             clk,
	input logic             rst,
	input logic             stall_decode,
	input logic             branch_en,
	input pipe_pkg::pc_t    branch_addr,
	input logic             stall0,
	input logic             stall1,
	input logic             halted,       // Issue state is HALTED
	input pipe_pkg::pc_t    pc,
	input pipe_pkg::pc_t    next_pc,
	input isa_pkg::opcode_e opcode0_ex,
	input isa_pkg::opcode_e opcode1_ex
);
	int unsigned fail_count = 0; // Failed assertions so far

	a_stall_mask: assert property (@(posedge clk) disable iff (rst)
		branch_en |-> !stall0 && !stall1) // Fetch sees no stall on a redirect
		else begin
			$error("stall0 or stall1 high while branch_en is set");
			fail_count++;
		end

	a_halt_noop: assert property (@(posedge clk) disable iff (rst)
		halted |=> opcode0_ex == isa_pkg::NOOP && opcode1_ex == isa_pkg::NOOP)
		else begin
			$error("an instruction issued while the stage was halted");
			fail_count++;
		end

	a_stall_noop: assert property (@(posedge clk) disable iff (rst)
		stall_decode |=> opcode0_ex == isa_pkg::NOOP && opcode1_ex == isa_pkg::NOOP)
		else begin
			$error("an instruction issued under stall_decode");
			fail_count++;
		end

	// Redirect overrides the step by the number of slots that leave decode
	a_next_pc: assert property (@(posedge clk) disable iff (rst)
		next_pc == (branch_en ? branch_addr
			: (stall_decode || halted) ? pc
			: pc + pipe_pkg::pc_t'(stall1 ? 1 : 2)))
		else begin
			$error("next_pc does not follow the fetch address rule");
			fail_count++;
		end

	a_reset_noop: assert property (@(posedge clk)
		$fell(rst) |-> opcode0_ex == isa_pkg::NOOP && opcode1_ex == isa_pkg::NOOP && pc == '0)
		else begin
			$error("execute opcodes or PC not cleared by reset");
			fail_count++;
		end

endmodule

bind dual_decode_top tb_decode_chk i_chk (
	.clk, .rst, .stall_decode, .branch_en, .branch_addr, .stall0, .stall1,
	.halted, .pc, .next_pc, .opcode0_ex, .opcode1_ex
);

// File: sim/tb_dual_decode.sv
`include "decode_settings.svh"

module tb_dual_decode;
	localparam int MAX_CYCLES = 2000; // Six tests of up to about 200 cycles, with margin

	logic                clk;
	logic                rst;
	logic                stall_decode;
	logic                halt_in_wb;
	logic                branch_en;
	isa_pkg::instr_t     instr0;
	isa_pkg::instr_t     instr1;
	pipe_pkg::reg_addr_t wb_addr0;
	pipe_pkg::reg_addr_t wb_addr1;
	pipe_pkg::data_t     wb_data0;
	pipe_pkg::data_t     wb_data1;
	logic                wb_en0;
	logic                wb_en1;
	pipe_pkg::pc_t       branch_addr;
	pipe_pkg::data_t     rm0_ex, rn0_ex, ro0_ex, rm1_ex, rn1_ex, ro1_ex;
	pipe_pkg::reg_addr_t rd0_ex, rd1_ex;
	isa_pkg::opcode_e    opcode0_ex, opcode1_ex;
	pipe_pkg::pc_t       next_pc;
	logic                stall0, stall1;

	pipe_pkg::data_t shadow [0:`UNUSED_REG]; // Expected register contents, r31 stays zero
	pipe_pkg::pc_t   pc_model;               // Address of the pair in decode
	logic            halted_model;
	string           test_name;
	int              test_errors;
	int              total_errors;
	int              tests_run;
	int              cycles;

	dual_decode_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	function automatic isa_pkg::instr_t enc(input isa_pkg::opcode_e op, input logic imm,
		input logic [21:0] body);
		return {op, 4'b0000, imm, body}; // Spare bits zero
	endfunction

	function automatic isa_pkg::instr_t alu(input isa_pkg::opcode_e op,
		input pipe_pkg::reg_addr_t rd, input pipe_pkg::reg_addr_t rm,
		input pipe_pkg::reg_addr_t rn);
		return enc(op, 1'b0, {rd, rm, rn, 7'd0}); // Register form
	endfunction

	// Low bits of v as a signed field, widened to the data width
	function automatic pipe_pkg::data_t sext(input logic [21:0] v, input int bits);
		pipe_pkg::data_t r;
		r = pipe_pkg::data_t'(v) << (`DATA_W - bits);
		return pipe_pkg::data_t'($signed(r) >>> (`DATA_W - bits));
	endfunction

	task automatic check(input string what, input pipe_pkg::data_t exp,
		input pipe_pkg::data_t act);
		assert (act === exp) else begin
			$display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("Test %s finished with %0d errors", test_name, test_errors);
		total_errors += test_errors;
		tests_run++;
	endtask

	// Same-cycle write-back on both ports, lands at the next edge
	task automatic write_back(input pipe_pkg::reg_addr_t a0, input pipe_pkg::data_t d0,
		input pipe_pkg::reg_addr_t a1, input pipe_pkg::data_t d1);
		wb_addr0 = a0;
		wb_data0 = d0;
		wb_en0   = 1'b1;
		wb_addr1 = a1;
		wb_data1 = d1;
		wb_en1   = 1'b1;
		if (!halted_model && a0 != `UNUSED_REG)
			shadow[a0] = d0;
		if (!halted_model && a1 != `UNUSED_REG)
			shadow[a1] = d1; // Port 1 lands last
	endtask

	// Starts and ends on a falling edge; adv is the expected PC step without redirect
	task automatic run_pair(input isa_pkg::instr_t i0, input isa_pkg::instr_t i1, input int adv,
		input isa_pkg::opcode_e op0, input isa_pkg::opcode_e op1);
		pipe_pkg::pc_t exp_next;
		instr0 = i0;
		instr1 = i1;
		exp_next = branch_en ? branch_addr : pc_model + pipe_pkg::pc_t'(adv);
		#5; // Fetch outputs settled, well before the rising edge
		check("next_pc", pipe_pkg::data_t'(exp_next), pipe_pkg::data_t'(next_pc));
		check("stall0", pipe_pkg::data_t'(stall_decode && !branch_en), pipe_pkg::data_t'(stall0));
		check("stall1", pipe_pkg::data_t'(!branch_en && (stall_decode || (!halted_model && adv < 2))),
			pipe_pkg::data_t'(stall1));
		@(negedge clk);
		pc_model = exp_next;
		wb_en0   = 1'b0;
		wb_en1   = 1'b0;
		check("opcode0_ex", pipe_pkg::data_t'(op0), pipe_pkg::data_t'(opcode0_ex));
		check("opcode1_ex", pipe_pkg::data_t'(op1), pipe_pkg::data_t'(opcode1_ex));
	endtask

	task automatic do_reset();
		rst          = 1'b1;
		stall_decode = 1'b0;
		halt_in_wb   = 1'b0;
		branch_en    = 1'b0;
		wb_en0       = 1'b0;
		wb_en1       = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst          = 1'b0;
		pc_model     = '0;
		halted_model = 1'b0;
		foreach (shadow[i])
			shadow[i] = '0;
	endtask

	task automatic test_write_read();
		pipe_pkg::reg_addr_t a0, a1, b0, b1;
		begin_test("write_read");
		for (int i = 0; i < 24; i++) begin
			a0 = pipe_pkg::reg_addr_t'($urandom);
			a1 = (i % 4 == 0) ? pipe_pkg::reg_addr_t'(`UNUSED_REG) : pipe_pkg::reg_addr_t'($urandom);
			b0 = pipe_pkg::reg_addr_t'($urandom);
			b1 = pipe_pkg::reg_addr_t'($urandom);
			write_back(a0, pipe_pkg::data_t'({$urandom, $urandom}),
				a1, pipe_pkg::data_t'({$urandom, $urandom}));
			// Slot 0 has no destination so the pair never holds back
			run_pair(alu(isa_pkg::ADD, 5'd31, a0, a1), alu(isa_pkg::SUB, b0, b0, b1), 2,
				isa_pkg::ADD, isa_pkg::SUB);
			check("rm0_ex", shadow[a0], rm0_ex); // Bypassed new data
			check("rn0_ex", shadow[a1], rn0_ex);
			check("rm1_ex", shadow[b0], rm1_ex);
			check("rn1_ex", shadow[b1], rn1_ex);
			check("rd1_ex", pipe_pkg::data_t'(b0), pipe_pkg::data_t'(rd1_ex));
		end
		end_test();
	endtask

	task automatic test_immediates();
		logic [21:0]   imm;
		pipe_pkg::pc_t pc_was;
		begin_test("immediates");
		for (int i = 0; i < 4; i++) begin
			imm = 22'($urandom);
			run_pair(enc(isa_pkg::ADD, 1'b1, {5'd5, 5'd3, imm[11:0]}),
				enc(isa_pkg::CMP, 1'b1, {5'd4, imm[16:0]}), 2, isa_pkg::ADD, isa_pkg::CMP);
			check("rm0_ex", shadow[3], rm0_ex);
			check("rn0_ex", sext(imm, 12), rn0_ex);
			check("rd0_ex", pipe_pkg::data_t'(5), pipe_pkg::data_t'(rd0_ex));
			check("rm1_ex", shadow[4], rm1_ex);
			check("rn1_ex", sext(imm, 17), rn1_ex);
			check("rd1_ex", pipe_pkg::data_t'(`UNUSED_REG), pipe_pkg::data_t'(rd1_ex));
			// LDR r7 from base r8, STR r9 to base r10
			run_pair(enc(isa_pkg::LDR, 1'b0, {4'd7, 5'd8, imm[12:0]}),
				enc(isa_pkg::STR, 1'b0, {4'd9, 5'd10, imm[12:0]}), 2, isa_pkg::LDR, isa_pkg::STR);
			check("rm0_ex", shadow[8], rm0_ex);
			check("rn0_ex", sext(imm, 13), rn0_ex);
			check("rd0_ex", pipe_pkg::data_t'(7), pipe_pkg::data_t'(rd0_ex));
			check("rm1_ex", shadow[10], rm1_ex);
			check("ro1_ex", shadow[9], ro1_ex); // Store data
			check("rd1_ex", pipe_pkg::data_t'(`UNUSED_REG), pipe_pkg::data_t'(rd1_ex));
			pc_was = pc_model;
			run_pair(enc(isa_pkg::B, 1'b1, imm), enc(isa_pkg::BL, 1'b1, ~imm), 2,
				isa_pkg::B, isa_pkg::BL);
			check("rm0_ex", pipe_pkg::data_t'(pc_was), rm0_ex);
			check("rn0_ex", sext(imm, 22), rn0_ex);
			check("rm1_ex", pipe_pkg::data_t'(pipe_pkg::pc_t'(pc_was + 1)), rm1_ex); // Slot 1 PC
			check("ro1_ex", pipe_pkg::data_t'(pipe_pkg::pc_t'(pc_was + 1)), ro1_ex);
			check("rd1_ex", pipe_pkg::data_t'(`LINK_REG), pipe_pkg::data_t'(rd1_ex));
			pc_was = pc_model;
			run_pair(enc(isa_pkg::BL, 1'b1, imm), enc(isa_pkg::NOOP, 1'b0, '0), 2,
				isa_pkg::BL, isa_pkg::NOOP);
			check("ro0_ex", pipe_pkg::data_t'(pc_was), ro0_ex);
			check("rd0_ex", pipe_pkg::data_t'(`LINK_REG), pipe_pkg::data_t'(rd0_ex));
		end
		end_test();
	endtask

	task automatic test_hazard();
		begin_test("hazard");
		run_pair(alu(isa_pkg::ADD, 5'd12, 5'd1, 5'd2), alu(isa_pkg::SUB, 5'd13, 5'd12, 5'd3), 1,
			isa_pkg::ADD, isa_pkg::NOOP); // Hit on rm
		run_pair(alu(isa_pkg::SUB, 5'd13, 5'd12, 5'd3), alu(isa_pkg::OR, 5'd14, 5'd4, 5'd13), 1,
			isa_pkg::SUB, isa_pkg::NOOP); // Hit on rn
		run_pair(alu(isa_pkg::OR, 5'd14, 5'd4, 5'd13), alu(isa_pkg::AND, 5'd15, 5'd5, 5'd6), 2,
			isa_pkg::OR, isa_pkg::AND);
		run_pair(alu(isa_pkg::ADD, 5'd17, 5'd1, 5'd2), alu(isa_pkg::BIC, 5'd17, 5'd3, 5'd4), 2,
			isa_pkg::ADD, isa_pkg::BIC); // Same rd, nothing read
		end_test();
	endtask

	task automatic test_stall();
		begin_test("stall");
		stall_decode = 1'b1;
		repeat (3)
			run_pair(alu(isa_pkg::ADD, 5'd20, 5'd1, 5'd2), alu(isa_pkg::RSB, 5'd21, 5'd3, 5'd4), 0,
				isa_pkg::NOOP, isa_pkg::NOOP);
		stall_decode = 1'b0;
		run_pair(alu(isa_pkg::ADD, 5'd20, 5'd1, 5'd2), alu(isa_pkg::RSB, 5'd21, 5'd3, 5'd4), 2,
			isa_pkg::ADD, isa_pkg::RSB);
		end_test();
	endtask

	task automatic test_branch();
		begin_test("branch");
		for (int i = 0; i < 4; i++) begin
			branch_addr  = pipe_pkg::pc_t'($urandom);
			branch_en    = 1'b1;
			stall_decode = (i % 2 == 0); // Hazard pair keeps stall1 up when not stalled
			run_pair(alu(isa_pkg::ADD, 5'd22, 5'd1, 5'd2), alu(isa_pkg::ADD, 5'd23, 5'd22, 5'd3), 1,
				stall_decode ? isa_pkg::NOOP : isa_pkg::ADD, isa_pkg::NOOP);
		end
		branch_en    = 1'b0;
		stall_decode = 1'b0;
		run_pair(alu(isa_pkg::AND, 5'd22, 5'd1, 5'd2), alu(isa_pkg::OR, 5'd23, 5'd4, 5'd3), 2,
			isa_pkg::AND, isa_pkg::OR);
		end_test();
	endtask

	task automatic test_halt();
		pipe_pkg::reg_addr_t a0, a1;
		begin_test("halt");
		run_pair(enc(isa_pkg::HALT, 1'b0, '0), alu(isa_pkg::ADD, 5'd24, 5'd1, 5'd2), 1,
			isa_pkg::HALT, isa_pkg::NOOP);
		halt_in_wb = 1'b1;
		run_pair(enc(isa_pkg::NOOP, 1'b0, '0), enc(isa_pkg::NOOP, 1'b0, '0), 2,
			isa_pkg::NOOP, isa_pkg::NOOP);
		halt_in_wb   = 1'b0;
		halted_model = 1'b1;
		for (int i = 0; i < 6; i++) begin
			a0 = pipe_pkg::reg_addr_t'($urandom);
			a1 = pipe_pkg::reg_addr_t'($urandom);
			write_back(a0, pipe_pkg::data_t'({$urandom, $urandom}),
				a1, pipe_pkg::data_t'({$urandom, $urandom})); // Must be dropped
			run_pair(alu(isa_pkg::ADD, 5'd25, a0, a1), alu(isa_pkg::SUB, 5'd26, 5'd7, 5'd8), 0,
				isa_pkg::NOOP, isa_pkg::NOOP);
			check("rm0_ex", shadow[a0], rm0_ex); // Operand payload still shows old contents
			check("rn0_ex", shadow[a1], rn0_ex);
		end
		do_reset();
		run_pair(alu(isa_pkg::ADD, 5'd25, a0, a1), alu(isa_pkg::SUB, 5'd26, 5'd7, 5'd8), 2,
			isa_pkg::ADD, isa_pkg::SUB); // Issue resumes, registers cleared
		check("rm0_ex", shadow[a0], rm0_ex);
		check("rn1_ex", shadow[8], rn1_ex);
		end_test();
	endtask

	initial begin
		void'($urandom(85642));
		rst          = 1'b1;
		stall_decode = 1'b0;
		halt_in_wb   = 1'b0;
		branch_en    = 1'b0;
		instr0       = enc(isa_pkg::NOOP, 1'b0, '0);
		instr1       = enc(isa_pkg::NOOP, 1'b0, '0);
		wb_addr0     = '0;
		wb_addr1     = '0;
		wb_data0     = '0;
		wb_data1     = '0;
		wb_en0       = 1'b0;
		wb_en1       = 1'b0;
		branch_addr  = '0;
		do_reset();
		test_write_read();
		test_immediates();
		test_hazard();
		test_stall();
		test_branch();
		test_halt();
		$display("Tests run: %0d, value errors: %0d, assertion failures: %0d",
			tests_run, total_errors, i_dut.i_chk.fail_count);
		if (total_errors == 0 && i_dut.i_chk.fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/decode_intf.sv
hdl/reg_file.sv
hdl/slot_decoder.sv
hdl/issue_control.sv
hdl/pc_sequencer.sv
hdl/dual_decode_top.sv
sim/tb_decode_chk.sv
sim/tb_dual_decode.sv
